// ==== include/decoder.svh ====
`ifndef DECODER_SVH
`define DECODER_SVH

// Group codes carried in grand_op
`define _ALU_GTYPE_LOG 2'd0
`define _ALU_GTYPE_INT 2'd1
`define _ALU_GTYPE_SFT 2'd2
`define _ALU_GTYPE_CMP 2'd3

// Logic group
`define _ALU_STYPE_NOR 2'd0
`define _ALU_STYPE_AND 2'd1
`define _ALU_STYPE_OR  2'd2
`define _ALU_STYPE_XOR 2'd3

// Arithmetic group
`define _ALU_STYPE_ADD   2'd0
`define _ALU_STYPE_MUL   2'd1
`define _ALU_STYPE_SUB   2'd2
`define _ALU_STYPE_PCADD 2'd3

// Shift group, code 3 decodes as SRA too
`define _ALU_STYPE_SLL 2'd0
`define _ALU_STYPE_SRL 2'd1
`define _ALU_STYPE_SRA 2'd2

// Compare group, bit 0 picks signed
`define _ALU_STYPE_SLTU 2'd0
`define _ALU_STYPE_SLT  2'd1

`endif

// ==== logic/exec_pkg.sv ====
package exec_pkg;

  // Data path width
  localparam int xlen = 32;

  // Execution lanes sharing the multiplier
  localparam int n_lanes = 2;

  // Tag carried with each product
  localparam int lane_id_w = 1;

  // Register stages after operand capture
  localparam int mul_stages = 2;

endpackage

// ==== logic/detachable_alu.sv ====
`timescale 1ns/10ps
`include "decoder.svh"

module detachable_alu import exec_pkg::*; #(
    parameter bit USE_LI  = 1,
    parameter bit USE_INT = 1,
    parameter bit USE_MUL = 0,
    parameter bit USE_SFT = 1,
    parameter bit USE_CMP = 1
  )(
    input  logic [xlen-1:0] mul_i,
    input  logic [xlen-1:0] r0_i,
    input  logic [xlen-1:0] r1_i,
    input  logic [xlen-1:0] pc_i,
    input  logic [1:0]      grand_op_i,
    input  logic [1:0]      op_i,

    output logic [xlen-1:0] res_o
  );

  logic [xlen-1:0] g_log;
  logic [xlen-1:0] g_int;
  logic [xlen-1:0] g_sft;
  logic [xlen-1:0] g_cmp;

  // Group field picks the result
  always_comb begin
    case (grand_op_i)
      `_ALU_GTYPE_LOG: begin
        res_o = g_log;
      end
      `_ALU_GTYPE_INT: begin
        res_o = g_int;
      end
      `_ALU_GTYPE_SFT: begin
        res_o = g_sft;
      end
      default: begin
        res_o = g_cmp;
      end
    endcase
  end

  if (USE_LI) begin : gen_log
    always_comb begin
      case (op_i)
        `_ALU_STYPE_NOR: begin
          g_log = ~(r1_i | r0_i);
        end
        `_ALU_STYPE_AND: begin
          g_log = r1_i & r0_i;
        end
        `_ALU_STYPE_OR: begin
          g_log = r1_i | r0_i;
        end
        default: begin
          g_log = r1_i ^ r0_i;
        end
      endcase
    end
  end
  else begin : gen_no_log
    assign g_log = '0;
  end

  if (USE_INT) begin : gen_int
    always_comb begin
      case (op_i)
        `_ALU_STYPE_ADD: begin
          g_int = r1_i + r0_i;
        end
        `_ALU_STYPE_SUB: begin
          g_int = r1_i - r0_i;
        end
        `_ALU_STYPE_PCADD: begin
          g_int = pc_i + r0_i;
        end
        default: begin
          g_int = USE_MUL ? mul_i : '0; // Product from the shared multiplier
        end
      endcase
    end
  end
  else if (USE_MUL) begin : gen_mul_only
    assign g_int = (op_i == `_ALU_STYPE_MUL) ? mul_i : '0;
  end
  else begin : gen_no_int
    assign g_int = '0;
  end

  if (USE_SFT) begin : gen_sft
    always_comb begin
      case (op_i)
        `_ALU_STYPE_SLL: begin
          g_sft = r1_i << r0_i[4:0];
        end
        `_ALU_STYPE_SRL: begin
          g_sft = r1_i >> r0_i[4:0];
        end
        default: begin
          g_sft = $unsigned($signed(r1_i) >>> r0_i[4:0]);
        end
      endcase
    end
  end
  else begin : gen_no_sft
    assign g_sft = '0;
  end

  if (USE_CMP) begin : gen_cmp
    logic        sgn;
    logic [xlen:0] cmp_a;
    logic [xlen:0] cmp_b;
    logic        lt;

    // Extra top bit is sign for SLT, zero for SLTU
    assign sgn   = op_i[0];
    assign cmp_a = {sgn & r1_i[xlen-1], r1_i};
    assign cmp_b = {sgn & r0_i[xlen-1], r0_i};
    assign lt    = $signed(cmp_a) < $signed(cmp_b);
    assign g_cmp = {{(xlen-1){1'b0}}, lt};
  end
  else begin : gen_no_cmp
    assign g_cmp = '0;
  end

endmodule

// ==== logic/mul_arbiter.sv ====
`timescale 1ns/10ps

module mul_arbiter import exec_pkg::*; (
    input  logic               clk,
    input  logic               rst_i,
    input  logic [n_lanes-1:0] req_i,

    output logic [n_lanes-1:0] gnt_o
  );

  logic last_q; // Lane that won the previous grant

  // Lane 0 wins a tie unless it won last time
  always_comb begin
    gnt_o = '0;
    if (req_i[0] && req_i[1]) begin
      if (last_q) begin
        gnt_o[0] = 1'b1;
      end
      else begin
        gnt_o[1] = 1'b1;
      end
    end
    else if (req_i[0]) begin
      gnt_o[0] = 1'b1;
    end
    else if (req_i[1]) begin
      gnt_o[1] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      last_q <= 1'b1; // Lane 0 first after reset
    end
    else if (|gnt_o) begin
      last_q <= gnt_o[1];
    end
  end

endmodule

// ==== logic/shared_multiplier.sv ====
`timescale 1ns/10ps

module shared_multiplier import exec_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic [n_lanes-1:0]   gnt_i,
    input  logic [xlen-1:0]      a0_i,
    input  logic [xlen-1:0]      b0_i,
    input  logic [xlen-1:0]      a1_i,
    input  logic [xlen-1:0]      b1_i,

    output logic                 prod_valid_o,
    output logic [lane_id_w-1:0] prod_id_o,
    output logic [xlen-1:0]      prod_o
  );

  logic [lane_id_w-1:0] gnt_id;
  logic                 cap_valid_q;
  logic [lane_id_w-1:0] cap_id_q;
  logic [xlen-1:0]      cap_a_q;
  logic [xlen-1:0]      cap_b_q;
  logic [xlen-1:0]      pp_lo_q;
  logic [xlen-1:0]      pp_hi_q;
  logic [xlen-1:0]      prod_q;
  logic [mul_stages-1:0] vld_q;
  logic [lane_id_w-1:0] id_q [mul_stages];

  // One-hot grant to lane tag
  always_comb begin
    gnt_id = '0;
    for (int i = 0; i < n_lanes; i++) begin
      if (gnt_i[i]) begin
        gnt_id = lane_id_w'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      cap_valid_q <= 1'b0;
      vld_q       <= '0;
    end
    else begin
      cap_valid_q <= |gnt_i;
      vld_q       <= {vld_q[mul_stages-2:0], cap_valid_q};
    end
  end

  always_ff @(posedge clk) begin
    cap_a_q  <= gnt_i[1] ? a1_i : a0_i;
    cap_b_q  <= gnt_i[1] ? b1_i : b0_i;
    cap_id_q <= gnt_id;
    // Low word only, split on the halves of b
    pp_lo_q  <= cap_a_q * cap_b_q[xlen/2-1:0];
    pp_hi_q  <= cap_a_q * cap_b_q[xlen-1:xlen/2];
    prod_q   <= pp_lo_q + (pp_hi_q << (xlen / 2));
    id_q[0]  <= cap_id_q;
    for (int i = 1; i < mul_stages; i++) begin
      id_q[i] <= id_q[i-1];
    end
  end

  assign prod_valid_o = vld_q[mul_stages-1];
  assign prod_id_o    = id_q[mul_stages-1];
  assign prod_o       = prod_q;

endmodule

// ==== logic/exec_lane.sv ====
`timescale 1ns/10ps
`include "decoder.svh"

module exec_lane import exec_pkg::*; #(
    parameter bit USE_LI  = 1,
    parameter bit USE_INT = 1,
    parameter bit USE_MUL = 1,
    parameter bit USE_SFT = 1,
    parameter bit USE_CMP = 1,
    parameter int LANE_ID = 0
  )(
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 valid_i,
    input  logic [1:0]           grand_op_i,
    input  logic [1:0]           op_i,
    input  logic [xlen-1:0]      r0_i,
    input  logic [xlen-1:0]      r1_i,
    input  logic [xlen-1:0]      pc_i,
    input  logic                 gnt_i,
    input  logic                 prod_valid_i,
    input  logic [lane_id_w-1:0] prod_id_i,
    input  logic [xlen-1:0]      prod_i,

    output logic                 mul_req_o,
    output logic [xlen-1:0]      mul_a_o,
    output logic [xlen-1:0]      mul_b_o,
    output logic                 valid_o,
    output logic [xlen-1:0]      res_o,
    output logic                 busy_o
  );

  logic            issue;
  logic            is_mul;
  logic            mul_done;
  logic            busy_q;
  logic            req_q;
  logic            valid_q;
  logic [xlen-1:0] res_q;
  logic [xlen-1:0] pend_a_q;
  logic [xlen-1:0] pend_b_q;
  logic [xlen-1:0] alu_res;
  logic [1:0]      alu_gop;
  logic [1:0]      alu_op;

  assign issue    = valid_i && !busy_q;
  assign is_mul   = USE_MUL && (grand_op_i == `_ALU_GTYPE_INT) && (op_i == `_ALU_STYPE_MUL);
  assign mul_done = busy_q && !req_q && prod_valid_i && (prod_id_i == lane_id_w'(LANE_ID));

  // While a multiply is pending the ALU only passes the product
  assign alu_gop = busy_q ? `_ALU_GTYPE_INT : grand_op_i;
  assign alu_op  = busy_q ? `_ALU_STYPE_MUL : op_i;

  detachable_alu #(
    .USE_LI  (USE_LI),
    .USE_INT (USE_INT),
    .USE_MUL (USE_MUL),
    .USE_SFT (USE_SFT),
    .USE_CMP (USE_CMP)
  ) u_alu (
    .mul_i      (prod_i),
    .r0_i       (r0_i),
    .r1_i       (r1_i),
    .pc_i       (pc_i),
    .grand_op_i (alu_gop),
    .op_i       (alu_op),
    .res_o      (alu_res)
  );

  always_ff @(posedge clk) begin
    if (rst_i) begin
      busy_q  <= 1'b0;
      req_q   <= 1'b0;
      valid_q <= 1'b0;
    end
    else begin
      valid_q <= (issue && !is_mul) || mul_done;
      if (issue && is_mul) begin
        busy_q <= 1'b1;
        req_q  <= 1'b1;
      end
      else begin
        if (req_q && gnt_i) begin
          req_q <= 1'b0; // Operands taken by the multiplier
        end
        if (mul_done) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue && is_mul) begin
      pend_a_q <= r0_i;
      pend_b_q <= r1_i;
    end
    if ((issue && !is_mul) || mul_done) begin
      res_q <= alu_res;
    end
  end

  assign mul_req_o = req_q;
  assign mul_a_o   = pend_a_q;
  assign mul_b_o   = pend_b_q;
  assign valid_o   = valid_q;
  assign res_o     = res_q;
  assign busy_o    = busy_q;

endmodule

// ==== logic/exec_cluster.sv ====
`timescale 1ns/10ps

module exec_cluster import exec_pkg::*; (
    input  logic            clk,
    input  logic            rst_i,

    input  logic            lane0_valid_i,
    input  logic [1:0]      lane0_grand_op_i,
    input  logic [1:0]      lane0_op_i,
    input  logic [xlen-1:0] lane0_r0_i,
    input  logic [xlen-1:0] lane0_r1_i,
    input  logic [xlen-1:0] lane0_pc_i,
    output logic            lane0_valid_o,
    output logic [xlen-1:0] lane0_res_o,
    output logic            lane0_busy_o,

    input  logic            lane1_valid_i,
    input  logic [1:0]      lane1_grand_op_i,
    input  logic [1:0]      lane1_op_i,
    input  logic [xlen-1:0] lane1_r0_i,
    input  logic [xlen-1:0] lane1_r1_i,
    input  logic [xlen-1:0] lane1_pc_i,
    output logic            lane1_valid_o,
    output logic [xlen-1:0] lane1_res_o,
    output logic            lane1_busy_o
  );

  logic [n_lanes-1:0]   mul_req;
  logic [n_lanes-1:0]   mul_gnt;
  logic [xlen-1:0]      mul_a0;
  logic [xlen-1:0]      mul_b0;
  logic [xlen-1:0]      mul_a1;
  logic [xlen-1:0]      mul_b1;
  logic                 prod_valid;
  logic [lane_id_w-1:0] prod_id;
  logic [xlen-1:0]      prod;

  exec_lane #(.LANE_ID(0)) u_lane0 (
    .clk          (clk),
    .rst_i        (rst_i),
    .valid_i      (lane0_valid_i),
    .grand_op_i   (lane0_grand_op_i),
    .op_i         (lane0_op_i),
    .r0_i         (lane0_r0_i),
    .r1_i         (lane0_r1_i),
    .pc_i         (lane0_pc_i),
    .gnt_i        (mul_gnt[0]),
    .prod_valid_i (prod_valid),
    .prod_id_i    (prod_id),
    .prod_i       (prod),
    .mul_req_o    (mul_req[0]),
    .mul_a_o      (mul_a0),
    .mul_b_o      (mul_b0),
    .valid_o      (lane0_valid_o),
    .res_o        (lane0_res_o),
    .busy_o       (lane0_busy_o)
  );

  // No shifter in lane 1
  exec_lane #(.USE_SFT(1'b0), .LANE_ID(1)) u_lane1 (
    .clk          (clk),
    .rst_i        (rst_i),
    .valid_i      (lane1_valid_i),
    .grand_op_i   (lane1_grand_op_i),
    .op_i         (lane1_op_i),
    .r0_i         (lane1_r0_i),
    .r1_i         (lane1_r1_i),
    .pc_i         (lane1_pc_i),
    .gnt_i        (mul_gnt[1]),
    .prod_valid_i (prod_valid),
    .prod_id_i    (prod_id),
    .prod_i       (prod),
    .mul_req_o    (mul_req[1]),
    .mul_a_o      (mul_a1),
    .mul_b_o      (mul_b1),
    .valid_o      (lane1_valid_o),
    .res_o        (lane1_res_o),
    .busy_o       (lane1_busy_o)
  );

  mul_arbiter u_arb (
    .clk   (clk),
    .rst_i (rst_i),
    .req_i (mul_req),
    .gnt_o (mul_gnt)
  );

  shared_multiplier u_mul (
    .clk          (clk),
    .rst_i        (rst_i),
    .gnt_i        (mul_gnt),
    .a0_i         (mul_a0),
    .b0_i         (mul_b0),
    .a1_i         (mul_a1),
    .b1_i         (mul_b1),
    .prod_valid_o (prod_valid),
    .prod_id_o    (prod_id),
    .prod_o       (prod)
  );

endmodule

// ==== sim/tb_exec_cluster.sv ====
`timescale 1ns/10ps
`include "decoder.svh"

module tb_exec_cluster import exec_pkg::*; ();

  // Every issue below, stalled attempts included
  localparam int n_issues       = 52;
  localparam int timeout_cycles = n_issues * (mul_stages + 4) + 200;

  logic            clk;
  logic            rst_i;
  logic            lane0_valid_i;
  logic [1:0]      lane0_grand_op_i;
  logic [1:0]      lane0_op_i;
  logic [xlen-1:0] lane0_r0_i;
  logic [xlen-1:0] lane0_r1_i;
  logic [xlen-1:0] lane0_pc_i;
  logic            lane0_valid_o;
  logic [xlen-1:0] lane0_res_o;
  logic            lane0_busy_o;
  logic            lane1_valid_i;
  logic [1:0]      lane1_grand_op_i;
  logic [1:0]      lane1_op_i;
  logic [xlen-1:0] lane1_r0_i;
  logic [xlen-1:0] lane1_r1_i;
  logic [xlen-1:0] lane1_pc_i;
  logic            lane1_valid_o;
  logic [xlen-1:0] lane1_res_o;
  logic            lane1_busy_o;

  int errors    = 0;
  int cycle_cnt = 0;
  int seed_dummy;

  exec_cluster u_dut (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // Expected result straight from the opcode rules
  function automatic logic [xlen-1:0] ref_alu(input bit has_sft, input logic [1:0] gop,
      input logic [1:0] op, input logic [xlen-1:0] r0, r1, pc);
    logic [4:0] sh;
    logic       lt;
    sh = r0[4:0];
    case (gop)
      `_ALU_GTYPE_LOG: begin
        case (op)
          `_ALU_STYPE_NOR: return ~(r0 | r1);
          `_ALU_STYPE_AND: return r0 & r1;
          `_ALU_STYPE_OR:  return r0 | r1;
          default:         return r0 ^ r1;
        endcase
      end
      `_ALU_GTYPE_INT: begin
        case (op)
          `_ALU_STYPE_ADD: return r1 + r0;
          `_ALU_STYPE_MUL: return r0 * r1; // Low word only
          `_ALU_STYPE_SUB: return r1 - r0;
          default:         return pc + r0;
        endcase
      end
      `_ALU_GTYPE_SFT: begin
        if (!has_sft) begin
          return '0;
        end
        case (op)
          `_ALU_STYPE_SLL: return r1 << sh;
          `_ALU_STYPE_SRL: return r1 >> sh;
          default:         return (r1 >> sh) | (r1[xlen-1] ? ~({xlen{1'b1}} >> sh) : '0);
        endcase
      end
      default: begin
        // Flipped sign bits make the unsigned compare a signed one
        if (op[0]) begin
          lt = (r1 ^ 32'h8000_0000) < (r0 ^ 32'h8000_0000);
        end
        else begin
          lt = r1 < r0;
        end
        return {{(xlen-1){1'b0}}, lt};
      end
    endcase
  endfunction

  function automatic logic out_valid(input int lane);
    return (lane == 0) ? lane0_valid_o : lane1_valid_o;
  endfunction

  function automatic logic out_busy(input int lane);
    return (lane == 0) ? lane0_busy_o : lane1_busy_o;
  endfunction

  function automatic logic [xlen-1:0] out_res(input int lane);
    return (lane == 0) ? lane0_res_o : lane1_res_o;
  endfunction

  task automatic check_res(input string name, input logic [xlen-1:0] got, exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic drive_lane(input int lane, input logic vld, input logic [1:0] gop, op,
      input logic [xlen-1:0] r0, r1, pc);
    if (lane == 0) begin
      lane0_valid_i    = vld;
      lane0_grand_op_i = gop;
      lane0_op_i       = op;
      lane0_r0_i       = r0;
      lane0_r1_i       = r1;
      lane0_pc_i       = pc;
    end
    else begin
      lane1_valid_i    = vld;
      lane1_grand_op_i = gop;
      lane1_op_i       = op;
      lane1_r0_i       = r0;
      lane1_r1_i       = r1;
      lane1_pc_i       = pc;
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst_i = 1'b1;
    drive_lane(0, 1'b0, 2'd0, 2'd0, '0, '0, '0);
    drive_lane(1, 1'b0, 2'd0, 2'd0, '0, '0, '0);
    repeat (16) @(negedge clk);
    rst_i = 1'b0;
  endtask

  // Non-multiply op, result due one cycle after issue
  task automatic run_single(input int lane, input logic [1:0] gop, op,
      input logic [xlen-1:0] r0, r1, pc);
    drive_lane(lane, 1'b1, gop, op, r0, r1, pc);
    @(negedge clk);
    drive_lane(lane, 1'b0, gop, op, r0, r1, pc);
    check_flag($sformatf("lane%0d_valid_o", lane), out_valid(lane), 1'b1);
    check_flag($sformatf("lane%0d_busy_o", lane), out_busy(lane), 1'b0);
    check_res($sformatf("lane%0d_res_o", lane), out_res(lane),
              ref_alu(lane == 0, gop, op, r0, r1, pc));
  endtask

  // Called one falling edge after a multiply issue
  task automatic wait_mul_result(input int lane, input logic [xlen-1:0] exp);
    int edges;
    edges = 0;
    while (!out_valid(lane)) begin
      check_flag($sformatf("lane%0d_busy_o", lane), out_busy(lane), 1'b1);
      @(negedge clk);
      edges++;
    end
    // Grant edge, product stages, then the result register
    if (edges < mul_stages + 2) begin
      errors++;
      $display("lane %0d multiply finished only %0d edges after issue", lane, edges);
    end
    check_flag($sformatf("lane%0d_busy_o", lane), out_busy(lane), 1'b0);
    check_res($sformatf("lane%0d_res_o", lane), out_res(lane), exp);
  endtask

  task automatic run_mul(input int lane);
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    a = $urandom;
    b = $urandom;
    drive_lane(lane, 1'b1, `_ALU_GTYPE_INT, `_ALU_STYPE_MUL, a, b, '0);
    @(negedge clk);
    drive_lane(lane, 1'b0, `_ALU_GTYPE_INT, `_ALU_STYPE_MUL, a, b, '0);
    wait_mul_result(lane, ref_alu(1'b1, `_ALU_GTYPE_INT, `_ALU_STYPE_MUL, a, b, '0));
  endtask

  task automatic test_logic_arith();
    logic [1:0] gop;
    logic [1:0] op;
    for (int rep = 0; rep < 2; rep++) begin
      for (int i = 0; i < 7; i++) begin
        if (i < 4) begin
          gop = `_ALU_GTYPE_LOG;
          op  = 2'(i);
        end
        else begin
          gop = `_ALU_GTYPE_INT;
          op  = (i == 4) ? `_ALU_STYPE_ADD : (i == 5) ? `_ALU_STYPE_SUB : `_ALU_STYPE_PCADD;
        end
        run_single(0, gop, op, $urandom, $urandom, $urandom);
      end
    end
  endtask

  task automatic test_shift_compare();
    logic [4:0]      amt;
    logic [xlen-1:0] r0;
    logic [xlen-1:0] r1;
    for (int sop = 0; sop < 3; sop++) begin
      for (int j = 0; j < 4; j++) begin
        amt = (j == 0) ? 5'd0 : (j == 1) ? 5'd1 : (j == 2) ? 5'd31 : 5'($urandom % 32);
        r0  = ($urandom & 32'hffff_ffe0) | amt; // Upper bits must not matter
        r1  = j[0] ? ($urandom | 32'h8000_0000) : ($urandom & 32'h7fff_ffff);
        run_single(0, `_ALU_GTYPE_SFT, 2'(sop), r0, r1, '0);
      end
    end
    // Signs differ, so SLT and SLTU disagree
    for (int cop = 0; cop < 2; cop++) begin
      run_single(0, `_ALU_GTYPE_CMP, 2'(cop), $urandom & 32'h7fff_ffff,
                 $urandom | 32'h8000_0000, '0);
      run_single(0, `_ALU_GTYPE_CMP, 2'(cop), $urandom | 32'h8000_0000,
                 $urandom & 32'h7fff_ffff, '0);
    end
    for (int sop = 0; sop < 4; sop++) begin
      run_single(1, `_ALU_GTYPE_SFT, 2'(sop), $urandom, $urandom, '0);
    end
  endtask

  task automatic test_mul_single();
    run_mul(0);
    run_mul(1);
  endtask

  // Simultaneous multiplies, first_lane is the one expected to finish first
  task automatic mul_pair(input int first_lane);
    logic [xlen-1:0] a[2];
    logic [xlen-1:0] b[2];
    bit              done[2];
    int              t[2];
    int              edges;
    for (int l = 0; l < 2; l++) begin
      a[l]    = $urandom;
      b[l]    = $urandom;
      done[l] = 1'b0;
      drive_lane(l, 1'b1, `_ALU_GTYPE_INT, `_ALU_STYPE_MUL, a[l], b[l], '0);
    end
    @(negedge clk);
    drive_lane(0, 1'b0, `_ALU_GTYPE_INT, `_ALU_STYPE_MUL, a[0], b[0], '0);
    drive_lane(1, 1'b0, `_ALU_GTYPE_INT, `_ALU_STYPE_MUL, a[1], b[1], '0);
    edges = 1;
    while (!(done[0] && done[1])) begin
      for (int l = 0; l < 2; l++) begin
        if (!done[l] && out_valid(l)) begin
          done[l] = 1'b1;
          t[l]    = edges;
          check_res($sformatf("lane%0d_res_o", l), out_res(l), a[l] * b[l]);
        end
      end
      if (!(done[0] && done[1])) begin
        @(negedge clk);
        edges++;
      end
    end
    if (t[0] == t[1] || (t[0] < t[1]) != (first_lane == 0)) begin
      errors++;
      $display("multiply order wrong, lane 0 at %0d, lane 1 at %0d, lane %0d expected first",
               t[0], t[1], first_lane);
    end
  endtask

  task automatic test_contention();
    apply_reset();
    mul_pair(0);
    run_mul(0); // Lane 0 won last, so lane 1 is next in line
    mul_pair(1);
  endtask

  task automatic test_mixed();
    logic [1:0]      s_gop[6];
    logic [1:0]      s_op[6];
    logic [xlen-1:0] s_r0[6];
    logic [xlen-1:0] s_r1[6];
    logic [xlen-1:0] s_pc[6];
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    int              pulses;
    for (int i = 0; i < 6; i++) begin
      s_gop[i] = 2'($urandom);
      s_op[i]  = 2'($urandom);
      if (s_gop[i] == `_ALU_GTYPE_INT && s_op[i] == `_ALU_STYPE_MUL) begin
        s_op[i] = `_ALU_STYPE_ADD;
      end
      s_r0[i] = $urandom;
      s_r1[i] = $urandom;
      s_pc[i] = $urandom;
    end
    a      = $urandom;
    b      = $urandom;
    pulses = 0;
    drive_lane(0, 1'b1, `_ALU_GTYPE_INT, `_ALU_STYPE_MUL, a, b, '0);
    drive_lane(1, 1'b1, s_gop[0], s_op[0], s_r0[0], s_r1[0], s_pc[0]);
    for (int k = 1; k <= 8; k++) begin
      @(negedge clk);
      if (k <= 6) begin
        check_flag("lane1_valid_o", lane1_valid_o, 1'b1);
        check_flag("lane1_busy_o", lane1_busy_o, 1'b0);
        check_res("lane1_res_o", lane1_res_o,
                  ref_alu(1'b0, s_gop[k-1], s_op[k-1], s_r0[k-1], s_r1[k-1], s_pc[k-1]));
      end
      if (k < 6) begin
        drive_lane(1, 1'b1, s_gop[k], s_op[k], s_r0[k], s_r1[k], s_pc[k]);
      end
      else begin
        drive_lane(1, 1'b0, 2'd0, 2'd0, '0, '0, '0);
      end
      if (lane0_valid_o) begin
        pulses++;
        check_res("lane0_res_o", lane0_res_o, a * b);
      end
      drive_lane(0, lane0_busy_o, `_ALU_GTYPE_LOG, `_ALU_STYPE_AND, $urandom, $urandom, '0);
    end
    if (pulses != 1) begin
      errors++;
      $display("lane 0 gave %0d results for a single accepted multiply", pulses);
    end
  endtask

  initial begin
    seed_dummy = $urandom(98);
    rst_i      = 1'b1;
    drive_lane(0, 1'b0, 2'd0, 2'd0, '0, '0, '0);
    drive_lane(1, 1'b0, 2'd0, 2'd0, '0, '0, '0);
    apply_reset();
    test_logic_arith();
    test_shift_compare();
    test_mul_single();
    test_contention();
    test_mixed();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end
    else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+include
logic/exec_pkg.sv
logic/detachable_alu.sv
logic/mul_arbiter.sv
logic/shared_multiplier.sv
logic/exec_lane.sv
logic/exec_cluster.sv
sim/tb_exec_cluster.sv
